// File: include/pipe_ctrl_params.svh
`ifndef PIPE_CTRL_PARAMS_SVH
`define PIPE_CTRL_PARAMS_SVH

// ------------------------------------------------------------------------
// widths
// ------------------------------------------------------------------------
`define PC_REG_W 5	// register number
`define PC_ADDR_W 32	// instruction address

// ------------------------------------------------------------------------
// program counter constants
// ------------------------------------------------------------------------
`define PC_RESET_VEC 32'h0000_0000	// first fetch after reset

// interrupt and syscall handler entry
`define PC_TRAP_VEC 32'h0000_0080

`define PC_STEP 32'd4	// one instruction word

`endif

// File: verilog/pipe_ctrl_pkg.sv
`include "pipe_ctrl_params.svh"

package pipe_ctrl_pkg;

	// ------------------------------------------------------------------------
	// stage payloads, valid is always the top bit
	// ------------------------------------------------------------------------

	// decoded instruction sitting in ID
	typedef struct packed {
		logic valid;
		logic [`PC_REG_W-1:0] rs;
		logic [`PC_REG_W-1:0] rt;
		logic [`PC_REG_W-1:0] rd;
		logic mem_read;	// load
		logic mem_write;	// store
		logic reg_write;
		logic is_branch;
		logic is_jump;
		logic is_syscall;
		logic is_trap;
	} ifid_t;

	typedef struct packed {
		logic valid;
		logic [`PC_REG_W-1:0] rs;
		logic [`PC_REG_W-1:0] rt;
		logic [`PC_REG_W-1:0] rd;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_branch;
	} idex_t;

	typedef struct packed {
		logic valid;
		logic [`PC_REG_W-1:0] rd;
		logic reg_write;
		logic is_branch;	// still unresolved here
	} exmem_t;

	typedef struct packed {
		logic valid;
		logic [`PC_REG_W-1:0] rd;
		logic reg_write;
	} memwb_t;

	// ------------------------------------------------------------------------
	// controller outputs
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic bubble_ifid;
		logic bubble_idex;
		logic bubble_exmem;
		logic write_ifid;
		logic write_idex;
		logic write_exmem;
		logic write_memwb;
		logic write_pc;
	} stall_ctrl_t;

	// operand source for EX
	typedef enum logic [1:0] {
		FWD_NONE  = 2'b00,
		FWD_EXMEM = 2'b01,
		FWD_MEMWB = 2'b10
	} fwd_src_e;

endpackage

// File: verilog/stage_reg.sv
// one pipeline register, payload chosen by the instantiating stage
module stage_reg #(
	parameter type payload_t = pipe_ctrl_pkg::memwb_t
) (
	input  logic clk,
	input  logic rst_n,
	input  logic write,
	input  logic bubble,
	input  payload_t d,
	output payload_t q
);

	logic [$bits(payload_t)-1:0] d_bits;

	// a bubble keeps the fields but kills the instruction
	always_comb begin
		d_bits = d;
		if (bubble) begin
			d_bits[$bits(payload_t)-1] = 1'b0;	// valid bit
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= '0;
		end
		else if (bubble || write) begin	// bubble loads even without write
			q <= payload_t'(d_bits);
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// a stalled stage must not change between edges
	hold_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		(!write && !bubble) |=> (q == $past(q))
	) else $error("stage_reg changed while stalled");

endmodule

// File: verilog/hazard_stall_id.sv
// stall and bubble control, evaluated for the instruction in ID
module hazard_stall_id (
	input  pipe_ctrl_pkg::ifid_t ifid,
	input  pipe_ctrl_pkg::idex_t idex,
	input  pipe_ctrl_pkg::exmem_t exmem,
	input  logic mem_ready,
	input  logic branch_taken,
	input  logic int_trap,
	output pipe_ctrl_pkg::stall_ctrl_t ctrl,
	output logic trap_waiting
);

	logic branch_in_flight;
	logic store_then_load;
	logic load_use;
	logic id_redirect;
	logic flush;

	// ------------------------------------------------------------------------
	// hazard terms
	// ------------------------------------------------------------------------

	// unresolved branch further down, syscall must wait for it
	assign branch_in_flight = (idex.valid && idex.is_branch) ||
		(exmem.valid && exmem.is_branch);

	assign store_then_load = ifid.valid && ifid.mem_read &&
		idex.valid && idex.mem_write;

	assign load_use = ifid.valid && idex.valid && idex.mem_read &&
		((idex.rd == ifid.rs) || (idex.rd == ifid.rt));

	assign id_redirect = ifid.valid && (ifid.is_jump || ifid.is_trap);
	assign flush = branch_taken || int_trap;	// redirect from MEM or outside

	// ------------------------------------------------------------------------
	// priority chain
	// ------------------------------------------------------------------------
	always_comb begin
		ctrl.bubble_ifid = 1'b0;
		ctrl.bubble_idex = 1'b0;
		ctrl.bubble_exmem = 1'b0;
		ctrl.write_ifid = 1'b1;
		ctrl.write_idex = 1'b1;
		ctrl.write_exmem = 1'b1;
		ctrl.write_memwb = 1'b1;
		ctrl.write_pc = 1'b1;
		trap_waiting = ifid.valid && ifid.is_syscall;

		if (!mem_ready) begin
			// whole pipe freezes
			ctrl.write_ifid = 1'b0;
			ctrl.write_idex = 1'b0;
			ctrl.write_exmem = 1'b0;
			ctrl.write_memwb = 1'b0;
			ctrl.write_pc = 1'b0;
			trap_waiting = 1'b0;
		end
		else if (ifid.valid && ifid.is_syscall && branch_in_flight) begin
			ctrl.bubble_idex = 1'b1;
			ctrl.write_ifid = 1'b0;	// pc keeps writing here
			trap_waiting = 1'b0;
		end
		else if (store_then_load) begin
			ctrl.bubble_idex = 1'b1;
			ctrl.write_ifid = 1'b0;
			ctrl.write_pc = 1'b0;
		end
		else if (load_use) begin
			ctrl.bubble_idex = 1'b1;	// one slot for the load data
			ctrl.write_ifid = 1'b0;
			ctrl.write_pc = 1'b0;
		end
		else if (id_redirect) begin
			ctrl.bubble_ifid = 1'b1;	// drop the fall-through fetch
		end

		// taken branch or interrupt squashes everything younger
		if (flush) begin
			ctrl.bubble_ifid = 1'b1;
			ctrl.bubble_idex = 1'b1;
			ctrl.bubble_exmem = 1'b1;
			ctrl.write_pc = 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// bubble_ifid only comes from a redirect in ID, which never stalls IF/ID
	always_comb begin
		ifid_bubble_vs_hold: assert (flush || !(ctrl.bubble_ifid && !ctrl.write_ifid))
			else $error("IF/ID bubbled and held without a flush");
	end

endmodule

// File: verilog/pc_sequencer.sv
`include "pipe_ctrl_params.svh"

// fetch address, redirected by trap, branch and jump
module pc_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic write_pc,
	input  logic int_trap,
	input  logic branch_taken,
	input  logic [`PC_ADDR_W-1:0] branch_target,
	input  logic jump_valid,
	input  logic [`PC_ADDR_W-1:0] jump_target,
	output logic [`PC_ADDR_W-1:0] pc
);

	logic [`PC_ADDR_W-1:0] pc_next;

	// oldest redirect wins, interrupt above everything
	always_comb begin
		if (int_trap) begin
			pc_next = `PC_TRAP_VEC;
		end
		else if (branch_taken) begin
			pc_next = branch_target;	// resolved in MEM
		end
		else if (jump_valid) begin
			pc_next = jump_target;	// jump decoded in ID
		end
		else begin
			pc_next = pc + `PC_STEP;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `PC_RESET_VEC;
		end
		else if (write_pc) begin
			pc <= pc_next;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// targets come from outside, so alignment is checked over time
	pc_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00
	) else $error("pc not word aligned: %h", pc);

endmodule

// File: verilog/forward_unit.sv
`include "pipe_ctrl_params.svh"

// operand bypass selects for the instruction in EX
module forward_unit (
	input  pipe_ctrl_pkg::idex_t idex,
	input  pipe_ctrl_pkg::exmem_t exmem,
	input  pipe_ctrl_pkg::memwb_t memwb,
	output pipe_ctrl_pkg::fwd_src_e fwd_a,
	output pipe_ctrl_pkg::fwd_src_e fwd_b
);

	logic exmem_ok;
	logic memwb_ok;

	// younger result first, then the one about to retire
	function automatic pipe_ctrl_pkg::fwd_src_e pick(
		input logic [`PC_REG_W-1:0] src,
		input logic ex_ok,
		input logic [`PC_REG_W-1:0] ex_rd,
		input logic wb_ok,
		input logic [`PC_REG_W-1:0] wb_rd
	);
		if (ex_ok && (ex_rd == src)) begin
			pick = pipe_ctrl_pkg::FWD_EXMEM;
		end
		else if (wb_ok && (wb_rd == src)) begin
			pick = pipe_ctrl_pkg::FWD_MEMWB;
		end
		else begin
			pick = pipe_ctrl_pkg::FWD_NONE;
		end
	endfunction

	// ------------------------------------------------------------------------
	// producers that can bypass
	// ------------------------------------------------------------------------

	// r0 is hardwired, never a producer
	assign exmem_ok = exmem.valid && exmem.reg_write && (exmem.rd != '0);
	assign memwb_ok = memwb.valid && memwb.reg_write && (memwb.rd != '0);

	// ------------------------------------------------------------------------
	// selects
	// ------------------------------------------------------------------------
	assign fwd_a = idex.valid ?
		pick(idex.rs, exmem_ok, exmem.rd, memwb_ok, memwb.rd) :
		pipe_ctrl_pkg::FWD_NONE;

	assign fwd_b = idex.valid ?
		pick(idex.rt, exmem_ok, exmem.rd, memwb_ok, memwb.rd) :
		pipe_ctrl_pkg::FWD_NONE;	// bubble in EX

endmodule

// File: verilog/pipe_ctrl_top.sv
`include "pipe_ctrl_params.svh"

module pipe_ctrl_top (
	input  logic clk,
	input  logic rst_n,
	input  pipe_ctrl_pkg::ifid_t fetch_in,
	input  logic mem_ready,
	input  logic branch_taken,
	input  logic [`PC_ADDR_W-1:0] branch_target,
	input  logic [`PC_ADDR_W-1:0] jump_target,
	input  logic int_trap,
	output logic [`PC_ADDR_W-1:0] pc,
	output pipe_ctrl_pkg::stall_ctrl_t ctrl,
	output logic trap_waiting,
	output pipe_ctrl_pkg::fwd_src_e fwd_a,
	output pipe_ctrl_pkg::fwd_src_e fwd_b
);

	pipe_ctrl_pkg::ifid_t ifid_q;
	pipe_ctrl_pkg::idex_t idex_d;
	pipe_ctrl_pkg::idex_t idex_q;
	pipe_ctrl_pkg::exmem_t exmem_d;
	pipe_ctrl_pkg::exmem_t exmem_q;
	pipe_ctrl_pkg::memwb_t memwb_d;
	pipe_ctrl_pkg::memwb_t memwb_q;
	logic jump_valid;

	// ------------------------------------------------------------------------
	// field narrowing between stages
	// ------------------------------------------------------------------------

	// ID drops the flags that are consumed in decode
	assign idex_d = '{
		valid: ifid_q.valid,
		rs: ifid_q.rs,
		rt: ifid_q.rt,
		rd: ifid_q.rd,
		mem_read: ifid_q.mem_read,
		mem_write: ifid_q.mem_write,
		reg_write: ifid_q.reg_write,
		is_branch: ifid_q.is_branch
	};

	assign exmem_d = '{
		valid: idex_q.valid,
		rd: idex_q.rd,
		reg_write: idex_q.reg_write,
		is_branch: idex_q.is_branch
	};

	assign memwb_d = '{
		valid: exmem_q.valid,
		rd: exmem_q.rd,
		reg_write: exmem_q.reg_write
	};

	assign jump_valid = ifid_q.valid && ifid_q.is_jump;

	// ------------------------------------------------------------------------
	// stage registers
	// ------------------------------------------------------------------------
	stage_reg #(.payload_t(pipe_ctrl_pkg::ifid_t)) u_ifid (
		.clk(clk),
		.rst_n(rst_n),
		.write(ctrl.write_ifid),
		.bubble(ctrl.bubble_ifid),
		.d(fetch_in),
		.q(ifid_q)
	);

	stage_reg #(.payload_t(pipe_ctrl_pkg::idex_t)) u_idex (
		.clk(clk),
		.rst_n(rst_n),
		.write(ctrl.write_idex),
		.bubble(ctrl.bubble_idex),
		.d(idex_d),
		.q(idex_q)
	);

	stage_reg #(.payload_t(pipe_ctrl_pkg::exmem_t)) u_exmem (
		.clk(clk),
		.rst_n(rst_n),
		.write(ctrl.write_exmem),
		.bubble(ctrl.bubble_exmem),
		.d(exmem_d),
		.q(exmem_q)
	);

	// nothing squashes WB, it only stalls
	stage_reg #(.payload_t(pipe_ctrl_pkg::memwb_t)) u_memwb (
		.clk(clk),
		.rst_n(rst_n),
		.write(ctrl.write_memwb),
		.bubble(1'b0),
		.d(memwb_d),
		.q(memwb_q)
	);

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------
	hazard_stall_id u_hazard_stall_id (
		.ifid(ifid_q),
		.idex(idex_q),
		.exmem(exmem_q),
		.mem_ready(mem_ready),
		.branch_taken(branch_taken),
		.int_trap(int_trap),
		.ctrl(ctrl),
		.trap_waiting(trap_waiting)
	);

	pc_sequencer u_pc_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.write_pc(ctrl.write_pc),
		.int_trap(int_trap),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.jump_valid(jump_valid),
		.jump_target(jump_target),
		.pc(pc)
	);

	forward_unit u_forward_unit (
		.idex(idex_q),
		.exmem(exmem_q),
		.memwb(memwb_q),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

endmodule

// File: dv/pipe_ctrl_tb.sv
`include "pipe_ctrl_params.svh"

module pipe_ctrl_tb;

	// ctrl and fwd in a row are the values the next rising edge acts on
	typedef struct {
		pipe_ctrl_pkg::ifid_t fetch;
		logic [2:0] lines;	// mem_ready, branch_taken, int_trap
		logic [`PC_ADDR_W-1:0] btgt;	// branch target
		logic [`PC_ADDR_W-1:0] jtgt;	// jump target
		pipe_ctrl_pkg::stall_ctrl_t exp_ctrl;
		logic exp_trap;
		pipe_ctrl_pkg::fwd_src_e exp_fa;
		pipe_ctrl_pkg::fwd_src_e exp_fb;
		logic [`PC_ADDR_W-1:0] exp_pc;	// pc after the edge
	} row_t;

	// {bubble ifid/idex/exmem, write ifid/idex/exmem/memwb/pc}
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_norm = 8'h1f;
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_stall = 8'h4e;	// load hazards
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_sys = 8'h4f;	// syscall behind branch
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_frz = 8'h00;
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_jmp = 8'h9f;
	localparam pipe_ctrl_pkg::stall_ctrl_t ctl_flush = 8'hff;
	localparam pipe_ctrl_pkg::fwd_src_e fw_no = pipe_ctrl_pkg::FWD_NONE;
	localparam pipe_ctrl_pkg::fwd_src_e fw_ex = pipe_ctrl_pkg::FWD_EXMEM;
	localparam pipe_ctrl_pkg::fwd_src_e fw_wb = pipe_ctrl_pkg::FWD_MEMWB;

	logic clk;
	logic rst_n;
	pipe_ctrl_pkg::ifid_t fetch_in;
	logic mem_ready;
	logic branch_taken;
	logic [`PC_ADDR_W-1:0] branch_target;
	logic [`PC_ADDR_W-1:0] jump_target;
	logic int_trap;
	logic [`PC_ADDR_W-1:0] pc;
	pipe_ctrl_pkg::stall_ctrl_t ctrl;
	logic trap_waiting;
	pipe_ctrl_pkg::fwd_src_e fwd_a;
	pipe_ctrl_pkg::fwd_src_e fwd_b;

	row_t rows[$];
	logic [7:0] lfsr_q;
	int error_count;

	pipe_ctrl_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_in(fetch_in),
		.mem_ready(mem_ready),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.jump_target(jump_target),
		.int_trap(int_trap),
		.pc(pc),
		.ctrl(ctrl),
		.trap_waiting(trap_waiting),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	// ------------------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------------------

	// galois lfsr with taps x^8+x^6+x^5+x^4+1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
	endfunction

	function automatic logic [3:0] rand_nibble();
		logic [3:0] v;
		for (int k = 0; k < 4; k++) begin
			v[k] = lfsr_q[0];	// one step per bit
			lfsr_q = lfsr_step(lfsr_q);
		end
		rand_nibble = v;
	endfunction

	// regs 16..31 without a register write never form a hazard
	function automatic pipe_ctrl_pkg::ifid_t filler();
		pipe_ctrl_pkg::ifid_t i;
		i = '0;
		i.valid = 1'b1;
		i.rs = {1'b1, rand_nibble()};
		i.rt = {1'b1, rand_nibble()};
		i.rd = {1'b1, rand_nibble()};
		filler = i;
	endfunction

	function automatic pipe_ctrl_pkg::ifid_t flagged(input int kind);
		pipe_ctrl_pkg::ifid_t i;
		i = filler();
		i.is_jump = (kind == 0);
		i.is_branch = (kind == 1);
		i.is_syscall = (kind == 2);
		flagged = i;
	endfunction

	function automatic pipe_ctrl_pkg::ifid_t alu(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd);
		pipe_ctrl_pkg::ifid_t i;
		i = '0;
		i.valid = 1'b1;
		i.rs = rs;
		i.rt = rt;
		i.rd = rd;
		i.reg_write = 1'b1;
		alu = i;
	endfunction

	function automatic pipe_ctrl_pkg::ifid_t load(input logic [4:0] rs, input logic [4:0] rd);
		pipe_ctrl_pkg::ifid_t i;
		i = alu(rs, rs, rd);
		i.mem_read = 1'b1;
		load = i;
	endfunction

	function automatic pipe_ctrl_pkg::ifid_t store(input logic [4:0] rs, input logic [4:0] rt);
		pipe_ctrl_pkg::ifid_t i;
		i = alu(rs, rt, 5'd0);
		i.reg_write = 1'b0;
		i.mem_write = 1'b1;
		store = i;
	endfunction

	task automatic add_row(input pipe_ctrl_pkg::ifid_t f, input logic [2:0] lines,
		input logic [31:0] btgt, input logic [31:0] jtgt,
		input pipe_ctrl_pkg::stall_ctrl_t ec, input logic et,
		input pipe_ctrl_pkg::fwd_src_e fa, input pipe_ctrl_pkg::fwd_src_e fb,
		input logic [31:0] epc);
		row_t r;
		r.fetch = f;
		r.lines = lines;
		r.btgt = btgt;
		r.jtgt = jtgt;
		r.exp_ctrl = ec;
		r.exp_trap = et;
		r.exp_fa = fa;
		r.exp_fb = fb;
		r.exp_pc = epc;
		rows.push_back(r);
	endtask

	// ------------------------------------------------------------------------
	// expected table
	// ------------------------------------------------------------------------

	// pc is already 4 here after one idle cycle out of reset
	task automatic build_rows();
		lfsr_q = 8'd80;
		// independent stream
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h08);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h0c);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h10);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h14);
		// load-use on r3 and the load result back from MEM/WB
		add_row(load(5'd20, 5'd3), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h18);
		add_row(alu(5'd3, 5'd21, 5'd6), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h1c);
		add_row(filler(), 3'b100, 0, 0, ctl_stall, 1'b0, fw_no, fw_no, 32'h1c);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h20);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_wb, fw_no, 32'h24);
		// load behind a store
		add_row(store(5'd22, 5'd23), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h28);
		add_row(load(5'd24, 5'd7), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h2c);
		add_row(filler(), 3'b100, 0, 0, ctl_stall, 1'b0, fw_no, fw_no, 32'h2c);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h30);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h34);
		// memory not ready for three cycles
		add_row(filler(), 3'b000, 0, 0, ctl_frz, 1'b0, fw_no, fw_no, 32'h34);
		add_row(filler(), 3'b000, 0, 0, ctl_frz, 1'b0, fw_no, fw_no, 32'h34);
		add_row(filler(), 3'b000, 0, 0, ctl_frz, 1'b0, fw_no, fw_no, 32'h34);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h38);
		// interrupt alone, a branch, interrupt over branch and then a jump
		add_row(filler(), 3'b101, 32'h600, 32'h700, ctl_flush, 1'b0, fw_no, fw_no,
			`PC_TRAP_VEC);
		add_row(filler(), 3'b110, 32'h200, 32'h500, ctl_flush, 1'b0, fw_no, fw_no, 32'h200);
		add_row(filler(), 3'b111, 32'h300, 32'h340, ctl_flush, 1'b0, fw_no, fw_no,
			`PC_TRAP_VEC);
		add_row(flagged(0), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h84);
		add_row(filler(), 3'b100, 32'h380, 32'h400, ctl_jmp, 1'b0, fw_no, fw_no, 32'h400);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h404);
		// forwarding of r5 then r0 then r11 written twice
		add_row(alu(5'd16, 5'd17, 5'd5), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h408);
		add_row(alu(5'd5, 5'd18, 5'd8), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h40c);
		add_row(alu(5'd19, 5'd5, 5'd9), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h410);
		add_row(alu(5'd0, 5'd0, 5'd0), 3'b100, 0, 0, ctl_norm, 1'b0, fw_ex, fw_no, 32'h414);
		add_row(alu(5'd0, 5'd20, 5'd10), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_wb, 32'h418);
		add_row(alu(5'd16, 5'd17, 5'd11), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h41c);
		add_row(alu(5'd18, 5'd19, 5'd11), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h420);
		add_row(alu(5'd11, 5'd11, 5'd12), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h424);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h428);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_ex, fw_ex, 32'h42c);
		// syscall alone then a syscall behind a branch
		add_row(flagged(2), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h430);
		add_row(flagged(1), 3'b100, 0, 0, ctl_norm, 1'b1, fw_no, fw_no, 32'h434);
		add_row(flagged(2), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h438);
		add_row(filler(), 3'b100, 0, 0, ctl_sys, 1'b0, fw_no, fw_no, 32'h43c);
		add_row(filler(), 3'b100, 0, 0, ctl_sys, 1'b0, fw_no, fw_no, 32'h440);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b1, fw_no, fw_no, 32'h444);
		add_row(filler(), 3'b100, 0, 0, ctl_norm, 1'b0, fw_no, fw_no, 32'h448);
	endtask

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timed out waiting for %s", what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic wait_pc(input logic [31:0] target);
		int n;
		n = 0;
		while (pc !== target) begin
			if (n >= 2) begin
				timeout_fail("the pc redirect");
			end
			#1;
			n++;
		end
	endtask

	initial begin
		int n;
		row_t r;
		fetch_in = '0;
		mem_ready = 1'b1;
		branch_taken = 1'b0;
		branch_target = '0;
		jump_target = '0;
		int_trap = 1'b0;
		error_count = 0;
		build_rows();

		n = 0;
		do begin
			@(negedge clk);
			#1;
			n++;
			if (n > 20) begin
				timeout_fail("reset release");
			end
		end while (rst_n !== 1'b1);

		check("pc", `PC_RESET_VEC, pc);
		check("ctrl", 32'(ctl_norm), 32'(ctrl));
		check("trap_waiting", 32'(1'b0), 32'(trap_waiting));

		foreach (rows[k]) begin
			r = rows[k];
			@(negedge clk);
			fetch_in = r.fetch;
			{mem_ready, branch_taken, int_trap} = r.lines;
			branch_target = r.btgt;
			jump_target = r.jtgt;
			#1;
			check("ctrl", 32'(r.exp_ctrl), 32'(ctrl));
			check("trap_waiting", 32'(r.exp_trap), 32'(trap_waiting));
			check("fwd_a", 32'(r.exp_fa), 32'(fwd_a));
			check("fwd_b", 32'(r.exp_fb), 32'(fwd_b));
			@(posedge clk);
			if (r.lines[1] || r.lines[0] || r.exp_ctrl.bubble_ifid) begin
				wait_pc(r.exp_pc);
			end
			else begin
				#1;
			end
			check("pc", r.exp_pc, pc);
		end

		if (error_count == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+include
verilog/pipe_ctrl_pkg.sv
verilog/stage_reg.sv
verilog/hazard_stall_id.sv
verilog/pc_sequencer.sv
verilog/forward_unit.sv
verilog/pipe_ctrl_top.sv
dv/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module pipe_ctrl_tb -o sim_pipe_ctrl
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_pipe_ctrl 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
